// ==== common/hyperTestPkg.sv ====
// shared definitions for the HyperRAM test access subsystem
// bus widths, command bytes, register map and the command word view
`default_nettype none

package hyperTestPkg;

	// widths
	localparam int DQ_WIDTH       = 16;	// RAM data bus, buffer words
	localparam int BUF_ADDR_WIDTH = 8;	// 256-word buffers
	localparam int DIV_WIDTH      = 8;	// RAM clock divider register

	// command and address phase length, words before the bus turnaround
	localparam logic [BUF_ADDR_WIDTH-1:0] CA_WORDS  = 8'd8;
	localparam logic [BUF_ADDR_WIDTH-1:0] LAST_ADDR = '1;	// top buffer word

	// command bytes, upper half of pattern word 0
	localparam logic [7:0] CMD_WRITE = 8'h38;
	localparam logic [7:0] CMD_READ  = 8'hEB;

	// MCU register map
	localparam logic [1:0] REG_DIV    = 2'd0;	// RAM clock divider
	localparam logic [1:0] REG_CTRL   = 2'd1;	// bit 0 = test enable
	localparam logic [1:0] REG_STATUS = 2'd2;	// done + capture count

	// word 0 is both DQ data and the command,
	// so the same 16 bits get two views
	typedef union packed
	{
		logic [DQ_WIDTH-1:0] raw;	// as driven on DQ
		struct packed
		{
			logic [7:0] cmd;	// command byte
			logic [7:0] addr;	// first address byte
		} ca;
	} caWord_t;

endpackage

`default_nettype wire

// ==== memoryAccessTester/patternBuffer.sv ====
// pattern buffer, 256 words
// MCU write port, registered read port for the sequencer
`timescale 1ns/1ps
`default_nettype none

module patternBuffer
(
	input  wire                                    iCLK,
	input  wire  [hyperTestPkg::DQ_WIDTH-1:0]       memWd,
	input  wire  [hyperTestPkg::BUF_ADDR_WIDTH-1:0] memWa,
	input  wire                                    memWe,	// single-cycle strobe
	input  wire  [hyperTestPkg::BUF_ADDR_WIDTH-1:0] patRa,
	output logic [hyperTestPkg::DQ_WIDTH-1:0]       patRd
);

	// word 0..7 = command and address phase
	logic [hyperTestPkg::DQ_WIDTH-1:0] patMem [0:2**hyperTestPkg::BUF_ADDR_WIDTH-1];

	// MCU side
	always_ff @(posedge iCLK)
	begin
		if (memWe)
			patMem[memWa] <= memWd;
	end

	// sequencer side, one cycle latency
	always_ff @(posedge iCLK)
	begin
		patRd <= patMem[patRa];	// read every cycle
	end

endmodule

`default_nettype wire

// ==== memoryAccessTester/captureBuffer.sv ====
// capture buffer, 256 words
// stores read data on the RAM strobe, registered MCU readback
`timescale 1ns/1ps
`default_nettype none

module captureBuffer
(
	input  wire                                    iCLK,
	input  wire                                    iRST,
	input  wire  [hyperTestPkg::DQ_WIDTH-1:0]       ramRd,
	input  wire                                    ramRe,	// sampled every cycle
	input  wire                                    ramOe,
	input  wire  [hyperTestPkg::BUF_ADDR_WIDTH-1:0] memRa,
	output logic [hyperTestPkg::DQ_WIDTH-1:0]       memRd,
	output logic [hyperTestPkg::BUF_ADDR_WIDTH-1:0] capCount
);

	logic [hyperTestPkg::DQ_WIDTH-1:0]       capMem [0:2**hyperTestPkg::BUF_ADDR_WIDTH-1];
	logic [hyperTestPkg::BUF_ADDR_WIDTH-1:0] capWa;	// next capture slot
	logic                                   capStore;

	assign capStore = ramRe & ~ramOe;	// only after the turnaround
	assign capCount = capWa;

	always_ff @(posedge iCLK)
	begin
		if (capStore)
			capMem[capWa] <= ramRd;
		memRd <= capMem[memRa];	// MCU readback, one cycle
	end

	// write address, saturates at the top word
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			capWa <= '0;
		else if (capStore && (capWa != hyperTestPkg::LAST_ADDR))
			capWa <= capWa + 1'b1;
	end

endmodule

`default_nettype wire

// ==== memoryAccessTester/accessSequencer.sv ====
// HyperRAM access sequencer
// chip select, divided RAM clock, pattern walk, read turnaround and done
`timescale 1ns/1ps
`default_nettype none

module accessSequencer
(
	input  wire                                    iCLK,
	input  wire                                    iRST,
	input  wire                                    testEn,
	input  wire  [hyperTestPkg::DIV_WIDTH-1:0]      clkDiv,
	output logic [hyperTestPkg::BUF_ADDR_WIDTH-1:0] patRa,		// pattern read address
	input  wire  [hyperTestPkg::DQ_WIDTH-1:0]       patRd,		// one cycle after patRa
	output logic [hyperTestPkg::DQ_WIDTH-1:0]       ramDq,
	output logic                                   ramCs,		// active low
	output logic                                   ramClk,
	output logic                                   ramOe,		// low = memory drives
	output logic                                   testBusy,
	output logic                                   done		// sticky until reset
);

	hyperTestPkg::caWord_t                   patWord;	// pattern word, data or command view
	logic [hyperTestPkg::DIV_WIDTH-1:0]      divCnt;
	logic [hyperTestPkg::BUF_ADDR_WIDTH-1:0] patRaQ;	// address behind patRd
	logic                                   isRead;
	logic                                   divMax;
	logic                                   patStep;
	logic                                   doneSet;
	logic                                   oeSet;

	assign patWord.raw = patRd;
	assign ramDq       = patWord.raw;	// word held for a full RAM clock period
	assign testBusy    = ~ramCs;

	assign divMax  = (divCnt == clkDiv);		// end of one RAM clock phase
	assign patStep = ~ramCs & ~ramClk & divMax & ~done;	// RAM clock about to rise
	assign doneSet = patStep & (patRa == hyperTestPkg::LAST_ADDR - 1'b1);
	// turnaround once the command and address words are out
	assign oeSet   = patStep & isRead & (patRa == hyperTestPkg::CA_WORDS - 1'b1);

	// chip select follows enable until done
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			ramCs <= 1'b1;
		else
			ramCs <= ~(testEn & ~done);	// one cycle behind enable
	end

	// divider, runs 0..clkDiv only while selected
	always_ff @(posedge iCLK)
	begin
		if (iRST || ramCs)
			divCnt <= '0;
		else if (divMax)
			divCnt <= '0;
		else
			divCnt <= divCnt + 1'b1;
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			ramClk <= 1'b0;
		else if (~ramCs & divMax)
			ramClk <= ~ramClk;	// every clkDiv+1 cycles
	end

	// pattern walk
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			patRa  <= '0;
			patRaQ <= '0;
		end
		else
		begin
			if (patStep)
				patRa <= patRa + 1'b1;	// next word ready before the next edge
			patRaQ <= patRa;
		end
	end

	// command decode from the most recent word 0
	always_ff @(posedge iCLK)
	begin
		if (iRST)
			isRead <= 1'b0;
		else if (patRaQ == '0)
			isRead <= (patWord.ca.cmd == hyperTestPkg::CMD_READ);
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			ramOe <= 1'b1;	// write direction by default
			done  <= 1'b0;
		end
		else
		begin
			if (oeSet)
				ramOe <= 1'b0;	// stays low, memory owns DQ
			if (doneSet)
				done <= 1'b1;
		end
	end

	// no RAM clock edge without chip select
	clkOnlySelected: assert property (
		@(posedge iCLK) disable iff (iRST)
		$changed(ramClk) |-> $past(~ramCs)
	);

	// turnaround never inside the command and address phase
	oeAfterCaPhase: assert property (
		@(posedge iCLK) disable iff (iRST)
		$fell(ramOe) |-> (patRa >= hyperTestPkg::CA_WORDS)
	);

endmodule

`default_nettype wire

// ==== hw/mcuRegFile.sv ====
// MCU register file
// holds the RAM clock divider and test enable, reads back status
`timescale 1ns/1ps
`default_nettype none

module mcuRegFile
(
	input  wire                                    iCLK,
	input  wire                                    iRST,
	input  wire                                    regWe,		// single-cycle write strobe
	input  wire  [1:0]                             regAddr,
	input  wire  [hyperTestPkg::DQ_WIDTH-1:0]       regWd,
	output logic [hyperTestPkg::DQ_WIDTH-1:0]       regRd,		// combinational on regAddr
	output logic [hyperTestPkg::DIV_WIDTH-1:0]      clkDiv,
	output logic                                   testEn,
	input  wire                                    done,		// sticky, from sequencer
	input  wire  [hyperTestPkg::BUF_ADDR_WIDTH-1:0] capCount
);

	// register writes
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			clkDiv <= '0;
			testEn <= 1'b0;
		end
		else if (regWe)
		begin
			case (regAddr)
				hyperTestPkg::REG_DIV:
					clkDiv <= regWd[hyperTestPkg::DIV_WIDTH-1:0];
				hyperTestPkg::REG_CTRL:
					testEn <= regWd[0];	// clearing ends the run
				default:
					;	// status is read only
			endcase
		end
	end

	// readback mux, no wait state
	always_comb
	begin
		regRd = '0;
		case (regAddr)
			hyperTestPkg::REG_DIV:
				regRd[hyperTestPkg::DIV_WIDTH-1:0] = clkDiv;
			hyperTestPkg::REG_CTRL:
				regRd[0] = testEn;
			hyperTestPkg::REG_STATUS:
			begin
				regRd[hyperTestPkg::BUF_ADDR_WIDTH-1:0] = capCount;	// words captured
				regRd[hyperTestPkg::DQ_WIDTH-1]         = done;		// msb = done
			end
			default:
				regRd = '0;
		endcase
	end

	// divider must hold for the whole run, the sequencer compares against it live
	divStableWhileActive: assert property (
		@(posedge iCLK) disable iff (iRST)
		(testEn && !done) |=> $stable(clkDiv)
	);

endmodule

`default_nettype wire

// ==== hw/hyperTestTop.sv ====
// HyperRAM test access top level
// MCU register file plus the memory access tester blocks
`timescale 1ns/1ps
`default_nettype none

module hyperTestTop
(
	input  wire                                    iCLK,
	input  wire                                    iRST,
	// MCU pattern load
	input  wire  [hyperTestPkg::DQ_WIDTH-1:0]       memWd,
	input  wire  [hyperTestPkg::BUF_ADDR_WIDTH-1:0] memWa,
	input  wire                                    memWe,
	// MCU capture readback
	input  wire  [hyperTestPkg::BUF_ADDR_WIDTH-1:0] memRa,
	output logic [hyperTestPkg::DQ_WIDTH-1:0]       memRd,
	// MCU registers
	input  wire                                    regWe,
	input  wire  [1:0]                             regAddr,
	input  wire  [hyperTestPkg::DQ_WIDTH-1:0]       regWd,
	output logic [hyperTestPkg::DQ_WIDTH-1:0]       regRd,
	// RAM side
	output logic [hyperTestPkg::DQ_WIDTH-1:0]       ramDq,
	output logic                                   ramCs,
	output logic                                   ramClk,
	output logic                                   ramOe,
	input  wire  [hyperTestPkg::DQ_WIDTH-1:0]       ramRd,
	input  wire                                    ramRe,
	output logic                                   testBusy	// chip select active
);

	logic [hyperTestPkg::DIV_WIDTH-1:0]      clkDiv;
	logic                                   testEn;
	logic                                   done;
	logic [hyperTestPkg::BUF_ADDR_WIDTH-1:0] capCount;
	logic [hyperTestPkg::BUF_ADDR_WIDTH-1:0] patRa;
	logic [hyperTestPkg::DQ_WIDTH-1:0]       patRd;

	mcuRegFile regFile (
		.iCLK(iCLK), .iRST(iRST),
		.regWe(regWe), .regAddr(regAddr), .regWd(regWd), .regRd(regRd),
		.clkDiv(clkDiv), .testEn(testEn), .done(done), .capCount(capCount)
	);

	accessSequencer sequencer (
		.iCLK(iCLK), .iRST(iRST), .testEn(testEn), .clkDiv(clkDiv),
		.patRa(patRa), .patRd(patRd),
		.ramDq(ramDq), .ramCs(ramCs), .ramClk(ramClk), .ramOe(ramOe),
		.testBusy(testBusy), .done(done)
	);

	patternBuffer patBuf (
		.iCLK(iCLK), .memWd(memWd), .memWa(memWa), .memWe(memWe),
		.patRa(patRa), .patRd(patRd)
	);

	captureBuffer capBuf (
		.iCLK(iCLK), .iRST(iRST), .ramRd(ramRd), .ramRe(ramRe), .ramOe(ramOe),
		.memRa(memRa), .memRd(memRd), .capCount(capCount)
	);

endmodule

`default_nettype wire

// ==== testbench/tbHyperTest.sv ====
// testbench for the HyperRAM test access subsystem
// write run and read run against an inverting echo model of the RAM
`timescale 1ns/1ps
`default_nettype none

module tbHyperTest;

	localparam int DIV        = 3;		// RAM clock divider under test
	localparam int NUM_RUNS   = 2;
	localparam int WORDS_SENT = 255;	// walk stops as patRa reaches the top word
	localparam int WATCHDOG   = NUM_RUNS * 2 * 256 * (DIV + 1) * 4;

	logic        iCLK;
	logic        iRST    = 1'b1;
	logic [15:0] memWd   = '0;
	logic [7:0]  memWa   = '0;
	logic        memWe   = 1'b0;
	logic [7:0]  memRa   = '0;
	logic [15:0] memRd;
	logic        regWe   = 1'b0;
	logic [1:0]  regAddr = hyperTestPkg::REG_STATUS;	// status visible by default
	logic [15:0] regWd   = '0;
	logic [15:0] regRd;
	logic [15:0] ramDq;
	logic        ramCs;
	logic        ramClk;
	logic        ramOe;
	logic [15:0] ramRd   = '0;
	logic        ramRe   = 1'b0;
	logic        testBusy;

	logic [31:0] lfsr = 32'h7663eb27;
	logic [15:0] patWords [256];		// what the MCU loaded
	logic [15:0] sentQ [$];				// DQ at each rising ramClk
	logic [15:0] expQ [$];				// expected captures from the echo model
	logic        modelClk = 1'b0;
	logic        lastClk  = 1'b0;
	logic        lastOe   = 1'b1;
	logic        seenToggle = 1'b0;
	logic        writeRun   = 1'b0;
	int          levelLen   = 0;
	int          errCount   = 0;
	int          checkCount = 0;

	hyperTestTop UUT (
		.iCLK(iCLK), .iRST(iRST),
		.memWd(memWd), .memWa(memWa), .memWe(memWe), .memRa(memRa), .memRd(memRd),
		.regWe(regWe), .regAddr(regAddr), .regWd(regWd), .regRd(regRd),
		.ramDq(ramDq), .ramCs(ramCs), .ramClk(ramClk), .ramOe(ramOe),
		.ramRd(ramRd), .ramRe(ramRe), .testBusy(testBusy)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;	// 100 MHz
	end

	// one galois step per pattern bit
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic randWord(output logic [15:0] w);
		for (int b = 0; b < 16; b++)
		begin
			lfsr = lfsrStep(lfsr);
			w[b] = lfsr[0];
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			errCount++;
			$display("** Error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic writeWord(input logic [7:0] addr, input logic [15:0] data);
		@(posedge iCLK);
		memWe <= 1'b1;
		memWa <= addr;
		memWd <= data;
		@(posedge iCLK);
		memWe <= 1'b0;
	endtask

	task automatic loadPattern(input logic [7:0] cmd);
		logic [15:0] w;
		for (int i = 0; i < 256; i++)
		begin
			randWord(w);
			if (i == 0)
				w[15:8] = cmd;	// command byte in word 0
			patWords[i] = w;
			writeWord(8'(i), w);
		end
	endtask

	task automatic writeReg(input logic [1:0] addr, input logic [15:0] data);
		@(posedge iCLK);
		regWe   <= 1'b1;
		regAddr <= addr;
		regWd   <= data;
		@(posedge iCLK);
		regWe   <= 1'b0;
		regAddr <= hyperTestPkg::REG_STATUS;	// back to status polling
	endtask

	task automatic applyReset();
		@(posedge iCLK);
		iRST <= 1'b1;
		repeat (16) @(posedge iCLK);
		iRST <= 1'b0;
	endtask

	// polls the status done bit
	task automatic waitDone();
		@(negedge iCLK);
		while (!regRd[15])
			@(negedge iCLK);
	endtask

	// echo model returns inverted DQ on every ramClk edge after turnaround
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			ramRe <= 1'b0;
			expQ.delete();
		end
		else if ((ramClk !== modelClk) && !ramOe)
		begin
			ramRe <= 1'b1;
			ramRd <= ~ramDq;
			expQ.push_back(~ramDq);
		end
		else
			ramRe <= 1'b0;
		modelClk <= ramClk;
	end

	// RAM side monitor sampled mid-cycle
	always @(negedge iCLK)
	begin
		if (iRST)
		begin
			sentQ.delete();
			seenToggle = 1'b0;
			levelLen   = 0;
		end
		else
		begin
			if (ramClk !== lastClk)
			begin
				if (!ramCs && seenToggle)
					checkValue("clkLevel", DIV + 1, levelLen);	// full level only
				seenToggle = 1'b1;
				levelLen   = 1;
				if (ramClk)
					sentQ.push_back(ramDq);
			end
			else
				levelLen++;
			if (ramCs)
				seenToggle = 1'b0;
			if (writeRun && !ramCs)
				checkValue("writeOe", 1, 32'(ramOe));
			if (lastOe && !ramOe)
				checkValue("oeTurnaround", 32'(hyperTestPkg::CA_WORDS), sentQ.size());
		end
		lastClk = ramClk;
		lastOe  = ramOe;
	end

	initial
	begin
		repeat (16) @(posedge iCLK);
		iRST <= 1'b0;
		@(negedge iCLK);
		checkValue("resetCs", 1, 32'(ramCs));
		checkValue("resetOe", 1, 32'(ramOe));
		checkValue("resetClk", 0, 32'(ramClk));
		checkValue("resetBusy", 0, 32'(testBusy));
		checkValue("resetDone", 0, 32'(regRd[15]));

		// write run
		loadPattern(hyperTestPkg::CMD_WRITE);
		writeReg(hyperTestPkg::REG_DIV, 16'(DIV));
		writeRun = 1'b1;
		writeReg(hyperTestPkg::REG_CTRL, 16'h0001);
		@(negedge iCLK);
		checkValue("startIdle", 0, 32'(testBusy));	// testEn just rose
		@(negedge iCLK);
		checkValue("startBusy", 1, 32'(testBusy));	// chip select one cycle later
		waitDone();
		repeat (4) @(negedge iCLK);
		writeRun = 1'b0;
		checkValue("writeCs", 1, 32'(ramCs));
		checkValue("writeBusy", 0, 32'(testBusy));
		checkValue("writeWordCount", WORDS_SENT, sentQ.size());
		for (int k = 0; k < sentQ.size() && k < 256; k++)
			checkValue($sformatf("writeWord[%0d]", k), 32'(patWords[k]), 32'(sentQ[k]));

		// read run with only word 0 changed
		applyReset();
		patWords[0][15:8] = hyperTestPkg::CMD_READ;
		writeWord(8'd0, patWords[0]);
		writeReg(hyperTestPkg::REG_DIV, 16'(DIV));
		writeReg(hyperTestPkg::REG_CTRL, 16'h0001);
		waitDone();
		repeat (8) @(negedge iCLK);	// last echo lands in the buffer
		checkValue("readCs", 1, 32'(ramCs));
		checkValue("readOe", 0, 32'(ramOe));
		checkValue("readDone", 1, 32'(regRd[15]));
		checkValue("captureCount", 255, 32'(regRd[7:0]));
		checkValue("echoCount", 1, 32'(expQ.size() >= 255));
		for (int i = 0; i < 255 && i < expQ.size(); i++)
		begin
			@(posedge iCLK);
			memRa <= 8'(i);
			@(posedge iCLK);
			@(negedge iCLK);
			checkValue($sformatf("capture[%0d]", i), 32'(expQ[i]), 32'(memRd));
		end

		$display("checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// watchdog over both runs
	initial
	begin
		repeat (WATCHDOG) @(posedge iCLK);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG);
		$display("checks: %0d, errors: %0d", checkCount, errCount);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/hyperTestPkg.sv
memoryAccessTester/patternBuffer.sv
memoryAccessTester/captureBuffer.sv
memoryAccessTester/accessSequencer.sv
hw/mcuRegFile.sv
hw/hyperTestTop.sv
testbench/tbHyperTest.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tbHyperTest
FILELIST   := verilog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
SIM_LOG    := sim.log
PASS_MSG   := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(SIM_LOG)
	grep -qx "$(PASS_MSG)" $(SIM_LOG)

clean:
	rm -rf $(BUILD_DIR) $(SIM_LOG)
